//--- logic/peak_pkg.sv
package peak_pkg;

	// ----------------------------------------------------------------------
	// phase and bin number formats
	// ----------------------------------------------------------------------
	localparam int PHASE_W = 16;                    // phase in Q1.15
	typedef logic signed [PHASE_W-1:0] phase_t;     // phase of one bin

	localparam int BIN_W = 16;                      // bin number width
	typedef logic [BIN_W-1:0] bin_t;                // unsigned bin number

	// ----------------------------------------------------------------------
	// report word layout
	// ----------------------------------------------------------------------
	localparam int WORD_W = 32;                     // one report word
	typedef logic [WORD_W-1:0] word_t;

	localparam int MAG_HI_W = 16;                   // magnitude msbs carried per word
	typedef logic [MAG_HI_W-1:0] mag_hi_t;

	// header word of one range
	// peak bin in the upper half and centre magnitude msbs in the lower half
	function automatic word_t hdr_word(
		input bin_t    bin,                         // centre bin of the peak
		input mag_hi_t mag                          // top bits of centre magnitude
	);
		return {bin, mag};
	endfunction

	// raw word of one window slot
	function automatic word_t raw_word(
		input mag_hi_t mag,                         // top bits of slot magnitude
		input phase_t  phs                          // slot phase
	);
		return {mag, phs};                          // magnitude high, phase low
	endfunction

endpackage

//--- logic/bin_window.sv
module bin_window import peak_pkg::*; #(
	parameter type T          = logic [15:0],       // payload of one slot
	parameter int  SIDE       = 2,                  // bins on each side of centre
	parameter int  FRAME_BINS = 40,                 // bins per frame
	parameter bit  COUNT      = 1'b1                // enables the frame bin counter
)(
	input  logic clk,
	input  logic rst_n,
	input  logic shift,                             // accepted bin
	input  logic first,                             // sop of the accepted bin
	input  logic last,                              // eop of the accepted bin
	input  T     sample,
	output T     window [2*SIDE+1],                 // slot 0 is the oldest
	output logic win_valid,                         // pulse after each shift
	output bin_t center_bin,                        // bin number at window centre
	output logic center_ok,                         // centre bin is part of the frame
	output logic frame_start,                       // sop accept delayed one cycle
	output logic eop_seen                           // eop accept delayed two cycles
);

	localparam int NWIN = 2*SIDE + 1;

	// ----------------------------------------------------------------------
	// shift register of samples
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (shift)
		begin
			for (int i = 0; i < NWIN-1; i++)
			begin
				if (first)
					window[i] <= '0;                // drop slots of the old frame
				else
					window[i] <= window[i+1];       // age by one slot
			end
			window[NWIN-1] <= sample;               // newest bin enters at the top
		end
	end

	// ----------------------------------------------------------------------
	// frame bin counter and event pulses
	// ----------------------------------------------------------------------
	if (COUNT)
	begin : g_count
		bin_t cnt;                                  // bins taken in this frame
		bin_t bin_idx;                              // number of the bin being accepted
		logic eop_d1;                               // eop accept, first stage

		assign bin_idx = first ? '0 : cnt;

		always_ff @(posedge clk or negedge rst_n)
		begin
			if (!rst_n)
			begin
				cnt         <= '0;
				win_valid   <= 1'b0;
				frame_start <= 1'b0;
				eop_d1      <= 1'b0;
				eop_seen    <= 1'b0;
			end
			else
			begin
				if (shift)
					cnt <= bin_idx + bin_t'(1);     // restarts at 1 on sop
				win_valid   <= shift;
				frame_start <= shift & first;
				eop_d1      <= shift & last;
				eop_seen    <= eop_d1;              // trackers are settled by now
			end
		end

		assign center_bin = cnt - bin_t'(SIDE + 1); // newest bin minus SIDE
		assign center_ok  = cnt > bin_t'(SIDE);     // SIDE bins past the centre

		initial assert (FRAME_BINS < 2**BIN_W)
			else $fatal(1, "bin_window FRAME_BINS does not fit bin_t");

		// eop must land on the last bin of the frame and nowhere else
		a_frame_len : assert property (@(posedge clk) disable iff (!rst_n)
			shift |-> (last == (bin_idx == bin_t'(FRAME_BINS - 1))));
	end
	else
	begin : g_nocount
		assign win_valid   = 1'b0;                  // phase window needs no counter
		assign center_bin  = '0;
		assign center_ok   = 1'b0;
		assign frame_start = 1'b0;
		assign eop_seen    = 1'b0;
	end

endmodule

//--- logic/range_peak_tracker.sv
module range_peak_tracker import peak_pkg::*; #(
	parameter int MAG_W = 24,                       // magnitude width
	parameter int SIDE  = 2,                        // bins on each side of centre
	parameter int LO    = 0,                        // first bin of the range
	parameter int HI    = 12                        // first bin past the range
)(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             frame_start,           // new frame, clear stored peak
	input  logic             win_valid,             // window just shifted
	input  logic             center_ok,             // centre bin belongs to the frame
	input  bin_t             center_bin,
	input  logic [MAG_W-1:0] win_mag [2*SIDE+1],
	input  phase_t           win_phs [2*SIDE+1],
	output bin_t             peak_bin,              // centre bin of the best window
	output logic [MAG_W-1:0] peak_mag [2*SIDE+1],
	output phase_t           peak_phs [2*SIDE+1]
);

	logic in_range;                                 // centre lies in [LO, HI)
	logic higher;                                   // centre beats stored centre
	logic take;                                     // store the current window

	// ----------------------------------------------------------------------
	// update decision
	// ----------------------------------------------------------------------
	assign in_range = (int'(center_bin) >= LO) && (int'(center_bin) < HI);
	assign higher   = win_mag[SIDE] > peak_mag[SIDE]; // strict, first peak keeps a tie
	assign take     = win_valid & center_ok & in_range & higher;

	// ----------------------------------------------------------------------
	// stored peak window
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			peak_bin <= bin_t'(LO);                 // empty range reports its low border
			peak_mag <= '{default: '0};
		end
		else if (frame_start)
		begin
			peak_bin <= bin_t'(LO);
			peak_mag <= '{default: '0};             // any nonzero bin will win
		end
		else if (take)
		begin
			peak_bin <= center_bin;
			peak_mag <= win_mag;                    // whole neighbourhood
		end
	end

	always_ff @(posedge clk)
	begin
		if (frame_start)
			peak_phs <= '{default: '0};
		else if (take)
			peak_phs <= win_phs;                    // phases follow magnitudes
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	initial assert (LO < HI)
		else $fatal(1, "range_peak_tracker needs LO below HI");

	// the sop bin can never sit at the centre, so clear and update do not meet
	a_no_update_on_start : assert property (@(posedge clk) disable iff (!rst_n)
		frame_start |-> !take);

endmodule

//--- logic/peak_report_serializer.sv
module peak_report_serializer import peak_pkg::*; #(
	parameter int MAG_W  = 24,                      // magnitude width
	parameter int SIDE   = 2,                       // bins on each side of centre
	parameter int NPEAKS = 3                        // number of ranges
)(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             eop_seen,              // trackers hold the final peaks
	input  bin_t             peak_bin [NPEAKS],
	input  logic [MAG_W-1:0] peak_mag [NPEAKS][2*SIDE+1],
	input  phase_t           peak_phs [NPEAKS][2*SIDE+1],
	output logic             busy,                  // report pending or running
	output logic             source_valid,
	output logic             source_sop,
	output logic             source_eop,
	output word_t            source_data
);

	localparam int NWIN = 2*SIDE + 1;
	localparam int PK_W = (NPEAKS > 1) ? $clog2(NPEAKS) : 1;
	localparam int SL_W = (NWIN > 1) ? $clog2(NWIN) : 1;

	logic            run;                           // walker active after first word
	logic            go;                            // emit a word this cycle
	logic            in_hdr;                        // next word is a range header
	logic [SL_W-1:0] slot;                          // next window slot
	logic [PK_W-1:0] pk_idx;                        // current range
	logic            first_word;
	logic            last_word;
	word_t           next_word;

	// ----------------------------------------------------------------------
	// walker state
	// ----------------------------------------------------------------------
	assign go         = eop_seen | run;             // first word leaves with eop_seen
	assign first_word = in_hdr && (pk_idx == '0);
	assign last_word  = !in_hdr && (slot == SL_W'(NWIN - 1)) &&
		(pk_idx == PK_W'(NPEAKS - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run    <= 1'b0;
			in_hdr <= 1'b1;
			slot   <= '0;
			pk_idx <= '0;
		end
		else if (go)
		begin
			run <= !last_word;                      // stop after the final slot
			if (in_hdr)
				in_hdr <= 1'b0;                     // slots follow the header
			else if (slot == SL_W'(NWIN - 1))
			begin
				slot   <= '0;
				in_hdr <= 1'b1;
				if (last_word)
					pk_idx <= '0;                   // ready for the next frame
				else
					pk_idx <= pk_idx + PK_W'(1);
			end
			else
				slot <= slot + SL_W'(1);
		end
	end

	// ----------------------------------------------------------------------
	// word select and output registers
	// ----------------------------------------------------------------------
	always_comb
	begin
		if (in_hdr)
			next_word = hdr_word(peak_bin[pk_idx],
				peak_mag[pk_idx][SIDE][MAG_W-1 -: MAG_HI_W]);
		else
			next_word = raw_word(peak_mag[pk_idx][slot][MAG_W-1 -: MAG_HI_W],
				peak_phs[pk_idx][slot]);           // oldest slot first
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			source_valid <= 1'b0;
			source_sop   <= 1'b0;
			source_eop   <= 1'b0;
		end
		else
		begin
			source_valid <= go;                     // one unbroken run of words
			source_sop   <= go & first_word;
			source_eop   <= go & last_word;
		end
	end

	always_ff @(posedge clk)
	begin
		if (go)
			source_data <= next_word;
	end

	assign busy = eop_seen | run | source_valid;   // drops after the eop word

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	initial assert (MAG_W >= MAG_HI_W)
		else $fatal(1, "peak_report_serializer needs MAG_W of at least 16");

	// sop marks exactly the first valid word of a run
	a_sop_opens_run : assert property (@(posedge clk) disable iff (!rst_n)
		source_sop == (source_valid && !$past(source_valid)));

	// eop sits on the last valid word of a run
	a_eop_closes_run : assert property (@(posedge clk) disable iff (!rst_n)
		$past(source_eop) == ($past(source_valid) && !source_valid));

endmodule

//--- logic/peak_detect.sv
module peak_detect import peak_pkg::*; #(
	parameter int MAG_W              = 24,          // magnitude width
	parameter int SIDE               = 2,           // bins on each side of centre
	parameter int NPEAKS             = 3,           // number of ranges
	parameter int BORDERS [NPEAKS+1] = '{0, 12, 24, 36}, // range edges
	parameter int FRAME_BINS         = 40           // bins per frame
)(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             sink_valid,
	input  logic             sink_sop,
	input  logic             sink_eop,
	input  logic [MAG_W-1:0] sink_mag,              // unsigned magnitude
	input  phase_t           sink_phase,            // Q1.15
	output logic             sink_ready,            // low while a report is due
	output logic             source_valid,
	output logic             source_sop,
	output logic             source_eop,
	output word_t            source_data
);

	localparam int NWIN = 2*SIDE + 1;

	logic             accept;                       // bin taken this cycle
	logic             eop_hold;                     // eop taken, report not started yet
	logic             busy;
	logic [MAG_W-1:0] win_mag [NWIN];
	phase_t           win_phs [NWIN];
	logic             win_valid;
	bin_t             center_bin;
	logic             center_ok;
	logic             frame_start;
	logic             eop_seen;
	bin_t             pk_bin [NPEAKS];
	logic [MAG_W-1:0] pk_mag [NPEAKS][NWIN];
	phase_t           pk_phs [NPEAKS][NWIN];

	// ----------------------------------------------------------------------
	// input handshake
	// ----------------------------------------------------------------------
	assign accept     = sink_valid & sink_ready;
	assign sink_ready = !(eop_hold | busy);         // hold off the next frame

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			eop_hold <= 1'b0;
		else if (accept && sink_eop)
			eop_hold <= 1'b1;
		else if (eop_seen)
			eop_hold <= 1'b0;                       // serializer busy takes over
	end

	// ----------------------------------------------------------------------
	// bin windows
	// ----------------------------------------------------------------------
	bin_window #(.T(logic [MAG_W-1:0]), .SIDE(SIDE), .FRAME_BINS(FRAME_BINS),
		.COUNT(1'b1)) mag_window (
		.clk(clk), .rst_n(rst_n), .shift(accept), .first(sink_sop), .last(sink_eop),
		.sample(sink_mag), .window(win_mag), .win_valid(win_valid),
		.center_bin(center_bin), .center_ok(center_ok), .frame_start(frame_start),
		.eop_seen(eop_seen));

	bin_window #(.T(phase_t), .SIDE(SIDE), .FRAME_BINS(FRAME_BINS),
		.COUNT(1'b0)) phs_window (                 // counter lives in mag_window
		.clk(clk), .rst_n(rst_n), .shift(accept), .first(sink_sop), .last(sink_eop),
		.sample(sink_phase), .window(win_phs), .win_valid(), .center_bin(),
		.center_ok(), .frame_start(), .eop_seen());

	// ----------------------------------------------------------------------
	// one tracker per range, all on the same window
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < NPEAKS; i++)
	begin : g_range
		range_peak_tracker #(.MAG_W(MAG_W), .SIDE(SIDE), .LO(BORDERS[i]),
			.HI(BORDERS[i+1])) tracker_i (
			.clk(clk), .rst_n(rst_n), .frame_start(frame_start), .win_valid(win_valid),
			.center_ok(center_ok), .center_bin(center_bin), .win_mag(win_mag),
			.win_phs(win_phs), .peak_bin(pk_bin[i]), .peak_mag(pk_mag[i]),
			.peak_phs(pk_phs[i]));
	end

	peak_report_serializer #(.MAG_W(MAG_W), .SIDE(SIDE), .NPEAKS(NPEAKS)) serializer_i (
		.clk(clk), .rst_n(rst_n), .eop_seen(eop_seen), .peak_bin(pk_bin),
		.peak_mag(pk_mag), .peak_phs(pk_phs), .busy(busy), .source_valid(source_valid),
		.source_sop(source_sop), .source_eop(source_eop), .source_data(source_data));

	// last range needs SIDE bins after it to reach the centre
	initial assert (FRAME_BINS >= BORDERS[NPEAKS] + SIDE)
		else $fatal(1, "peak_detect FRAME_BINS too small for the last border");

endmodule

//--- verif/peak_frames.svh
`ifndef PEAK_FRAMES_SVH
`define PEAK_FRAMES_SVH

// ----------------------------------------------------------------------
// frame table, one row per test
// ----------------------------------------------------------------------
typedef enum logic [2:0] {SPIKES, BORDER, TIE, ZERO_RANGE, RANDOM} frame_kind_t;

localparam int NTESTS = 6;
localparam int NSPK   = 4;                          // spike slots per row, -1 marks unused

// columns: kind, idle gaps, spike bins, spike magnitudes, expected peak bin per range
frame_kind_t      tbl_kind [NTESTS] = '{SPIKES, BORDER, TIE, ZERO_RANGE, RANDOM, RANDOM};
bit               tbl_gap  [NTESTS] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
int               tbl_pos  [NTESTS][NSPK] = '{
	'{5, 17, 30, -1}, '{0, 23, 24, -1}, '{3, 8, 14, 20},
	'{5, 30, -1, -1}, '{-1, -1, -1, -1}, '{-1, -1, -1, -1}};
logic [MAG_W-1:0] tbl_val  [NTESTS][NSPK] = '{
	'{24'h123456, 24'h800000, 24'h00abcd, 24'h0},
	'{24'h7fffff, 24'h600000, 24'h200000, 24'h0},  // centre decides, not the window
	'{24'h300000, 24'h300000, 24'h300000, 24'h300001},  // tie, then strictly larger
	'{24'h40f0f0, 24'h0fffff, 24'h0, 24'h0},
	'{24'h0, 24'h0, 24'h0, 24'h0}, '{24'h0, 24'h0, 24'h0, 24'h0}};
int               tbl_bin  [NTESTS][NPEAKS] = '{
	'{5, 17, 30}, '{0, 23, 24}, '{3, 20, 27}, '{5, 12, 30},
	'{-1, -1, -1}, '{-1, -1, -1}};                  // -1 means taken from the model

logic [MAG_W-1:0] frame_mag [FRAME_BINS];           // current frame
phase_t           frame_phs [FRAME_BINS];
word_t            exp_words [$];                    // expected report
int               exp_bin   [NPEAKS];

// ----------------------------------------------------------------------
// frame generator
// ----------------------------------------------------------------------
function automatic void make_frame(input int t);
	for (int b = 0; b < FRAME_BINS; b++)
	begin
		if (tbl_kind[t] == RANDOM)
		begin
			frame_mag[b] = 24'($urandom);
			frame_phs[b] = phase_t'($urandom);
		end
		else
		begin
			frame_mag[b] = (tbl_kind[t] == ZERO_RANGE) ? 24'h0 : 24'((b % 7 + 1) * 256);
			frame_phs[b] = phase_t'(b * 2321 + t * 311); // differs per bin and test
		end
	end
	for (int s = 0; s < NSPK; s++)
		if (tbl_pos[t][s] >= 0)
			frame_mag[tbl_pos[t][s]] = tbl_val[t][s];
endfunction

// ----------------------------------------------------------------------
// reference model of the report
// ----------------------------------------------------------------------
function automatic void build_expected();
	int               best;
	int               b;
	logic [MAG_W-1:0] best_mag;
	logic [MAG_W-1:0] m;
	phase_t           p;
	exp_words.delete();
	for (int r = 0; r < NPEAKS; r++)
	begin
		best     = -1;                              // no centre above zero yet
		best_mag = '0;
		for (int c = BORDERS[r]; c < BORDERS[r+1]; c++)
			if (frame_mag[c] > best_mag)            // strict, first one keeps a tie
			begin
				best     = c;
				best_mag = frame_mag[c];
			end
		exp_bin[r] = (best < 0) ? BORDERS[r] : best;
		exp_words.push_back({bin_t'(exp_bin[r]), best_mag[MAG_W-1 -: MAG_HI_W]});
		for (int k = -SIDE; k <= SIDE; k++)
		begin
			b = best + k;                           // oldest slot first
			m = '0;
			p = '0;
			if (best >= 0 && b >= 0 && b < FRAME_BINS)
			begin
				m = frame_mag[b];
				p = frame_phs[b];
			end
			exp_words.push_back({m[MAG_W-1 -: MAG_HI_W], p});
		end
	end
endfunction

`endif

//--- verif/tb_peak_detect.sv
module tb_peak_detect import peak_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAG_W      = 24;
	localparam int SIDE       = 2;
	localparam int NPEAKS     = 3;
	localparam int FRAME_BINS = 40;
	localparam int BORDERS [NPEAKS+1] = '{0, 12, 24, 36};
	localparam int NWIN       = 2*SIDE + 1;
	localparam int NWORDS     = NPEAKS * (NWIN + 1);    // header plus slots per range
	localparam int SEED       = 71863;
	localparam int WAIT_LIMIT = 200;                    // cycles for any single wait

	logic             clk;
	logic             rst_n;
	logic             sink_valid, sink_sop, sink_eop, sink_ready;
	logic [MAG_W-1:0] sink_mag;
	phase_t           sink_phase;
	logic             source_valid, source_sop, source_eop;
	word_t            source_data;

	int               errors;
	int               checks;
	bit               timed_out;
	word_t            got_words [$];                    // collected report
	logic             got_sop [$];
	logic             got_eop [$];

	`include "peak_frames.svh"

	peak_detect #(.MAG_W(MAG_W), .SIDE(SIDE), .NPEAKS(NPEAKS), .BORDERS(BORDERS),
		.FRAME_BINS(FRAME_BINS)) peak_detect_i (
		.clk(clk), .rst_n(rst_n), .sink_valid(sink_valid), .sink_sop(sink_sop),
		.sink_eop(sink_eop), .sink_mag(sink_mag), .sink_phase(sink_phase),
		.sink_ready(sink_ready), .source_valid(source_valid), .source_sop(source_sop),
		.source_eop(source_eop), .source_data(source_data));

	always #4 clk = ~clk;                               // 8 ns period

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_word(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bin(input bin_t got, input bin_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] t=%0t %s: got bin %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] t=%0t %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------------------------------------
	// driver and monitor
	// ----------------------------------------------------------------------
	task automatic wait_ready();
		int n;
		n = 0;
		while (!sink_ready && !timed_out)
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
			begin
				timed_out = 1'b1;
				$display("timeout at %0t: sink_ready never went high", $time);
			end
		end
	endtask

	task automatic send_frame(input int t);
		for (int b = 0; b < FRAME_BINS && !timed_out; b++)
		begin
			if (tbl_gap[t])
				repeat ($urandom_range(0, 2))
				begin
					@(negedge clk);
					sink_valid = 1'b0;                  // idle cycle inside the frame
				end
			@(negedge clk);
			wait_ready();                               // holds off the sop too
			check_flag(source_valid, 1'b0, "source_valid while frame is sent");
			sink_valid = 1'b1;
			sink_sop   = (b == 0);
			sink_eop   = (b == FRAME_BINS - 1);
			sink_mag   = frame_mag[b];
			sink_phase = frame_phs[b];
		end
	endtask

	task automatic collect_report();
		int n;
		bit started;
		bit done;
		got_words.delete();
		got_sop.delete();
		got_eop.delete();
		n       = 0;
		started = 1'b0;
		done    = 1'b0;
		while (!done && !timed_out)
		begin
			@(negedge clk);
			sink_valid = 1'b0;
			sink_sop   = 1'b0;
			sink_eop   = 1'b0;
			check_flag(sink_ready, 1'b0, "sink_ready while report is due");
			if (source_valid)
			begin
				got_words.push_back(source_data);
				got_sop.push_back(source_sop);
				got_eop.push_back(source_eop);
				started = 1'b1;
				done    = source_eop;
			end
			else if (started)
			begin
				errors++;
				$display("report broken by an idle cycle at %0t", $time);
			end
			n++;
			if (n > WAIT_LIMIT && !done)
			begin
				timed_out = 1'b1;
				$display("timeout at %0t: report never ended with eop", $time);
			end
		end
		if (!timed_out)
		begin
			@(negedge clk);
			check_flag(sink_ready, 1'b1, "sink_ready after report");
			check_flag(source_valid, 1'b0, "source_valid after report");
		end
	endtask

	task automatic compare_report(input int t);
		int r;
		int eb;
		if (got_words.size() != NWORDS)
		begin
			errors++;
			$display("report of test %0d has %0d words, not %0d", t, got_words.size(), NWORDS);
		end
		for (int i = 0; i < got_words.size() && i < NWORDS; i++)
		begin
			check_word(got_words[i], exp_words[i], $sformatf("test %0d word %0d", t, i));
			check_flag(got_sop[i], (i == 0), "source_sop");
			check_flag(got_eop[i], (i == NWORDS - 1), "source_eop");
			if (i % (NWIN + 1) == 0)
			begin
				r  = i / (NWIN + 1);
				eb = (tbl_bin[t][r] < 0) ? exp_bin[r] : tbl_bin[t][r];
				check_bin(got_words[i][WORD_W-1 -: BIN_W], bin_t'(eb), "header peak bin");
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial
	begin
		int err_before;
		int passed;
		void'($urandom(SEED));
		clk        = 1'b0;
		rst_n      = 1'b0;
		sink_valid = 1'b0;
		sink_sop   = 1'b0;
		sink_eop   = 1'b0;
		sink_mag   = '0;
		sink_phase = '0;
		errors     = 0;
		checks     = 0;
		passed     = 0;
		timed_out  = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_flag(source_valid, 1'b0, "source_valid after reset");
		check_flag(source_sop, 1'b0, "source_sop after reset");
		check_flag(source_eop, 1'b0, "source_eop after reset");
		check_flag(sink_ready, 1'b1, "sink_ready after reset");
		$display("reset state checked, %0d errors", errors);
		for (int t = 0; t < NTESTS && !timed_out; t++)
		begin
			err_before = errors;
			make_frame(t);
			build_expected();
			send_frame(t);
			if (!timed_out)
				collect_report();
			if (!timed_out)
				compare_report(t);
			if (errors == err_before && !timed_out)
			begin
				passed++;
				$display("test %0d %s passed", t, tbl_kind[t].name());
			end
			else
				$display("test %0d %s failed", t, tbl_kind[t].name());
		end
		$display("%0d of %0d tests passed, %0d checks, %0d errors", passed, NTESTS, checks,
			errors);
		if (errors == 0 && !timed_out && passed == NTESTS)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+verif
logic/peak_pkg.sv
logic/bin_window.sv
logic/range_peak_tracker.sv
logic/peak_report_serializer.sv
logic/peak_detect.sv
verif/tb_peak_detect.sv

//--- run_verilator.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_peak_detect -f vlog.f -o tb_peak_detect

./obj_dir/tb_peak_detect | tee sim.log

if grep -qx "STATUS: PASS" sim.log
then
	echo "peak_detect simulation passed"
else
	echo "peak_detect simulation failed"
	exit 1
fi
